// File: tb.f
hw/tcm_pkg.sv
hw/lsu_align.sv
hw/bus_decoder.sv
hw/soc_memory.sv
hw/soc_gpio.sv
hw/tcm_subsystem.sv
tb/tb_top.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the tcm subsystem testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ns \
    -f tb.f --top-module tb_top -Mdir "$BUILD_DIR" -o tb_top
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/tb_top" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^SIMULATION PASSED$" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

// File: tb/tb_top.sv
// tcm subsystem testbench
`timescale 1ns/1ns

module tb_top;

    import tcm_pkg::*;

    localparam int unsigned MEM_SIZE  = 256;
    localparam int unsigned WORDS     = MEM_SIZE / 4;
    localparam int          MA        = $clog2(MEM_SIZE);
    localparam int unsigned GPIO_W    = 16;
    localparam logic [31:0] GPIO_BASE = 32'h0001_0000;
    localparam int          N_RAND    = 80;
    // zero sweep, random mix and directed accesses
    localparam int          N_ACCESS  = WORDS + N_RAND + 40;
    localparam int          LIMIT     = WORDS + N_ACCESS * 4 + 200;

    logic              sub;
    logic              rst;
    logic              req_valid;
    logic              req_ready;
    logic              req_write;
    logic [31:0]       req_addr;
    logic [1:0]        req_size;
    logic              req_signed;
    logic [31:0]       req_wdata;
    logic              rsp_valid;
    logic [31:0]       rsp_rdata;
    logic              rsp_err;
    logic [GPIO_W-1:0] gpio_in;
    logic [GPIO_W-1:0] gpio_out;

    // shadow state kept by the driver
    logic [7:0]  shadow_mem [MEM_SIZE];
    logic [31:0] shadow_out;
    logic [31:0] shadow_in;
    // one entry per transfer, popped at its response
    string       exp_name [$];
    logic [31:0] exp_data [$];
    logic        exp_err  [$];
    logic        exp_read [$];
    int          mismatches;
    int          failures;
    integer      seed;

    tcm_subsystem #(
        .MEM_SIZE  (MEM_SIZE),
        .GPIO_BASE (GPIO_BASE),
        .GPIO_W    (GPIO_W)
    ) dut_i (
        .sub        (sub),
        .rst        (rst),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req_write  (req_write),
        .req_addr   (req_addr),
        .req_size   (req_size),
        .req_signed (req_signed),
        .req_wdata  (req_wdata),
        .rsp_valid  (rsp_valid),
        .rsp_rdata  (rsp_rdata),
        .rsp_err    (rsp_err),
        .gpio_in    (gpio_in),
        .gpio_out   (gpio_out)
    );

    initial begin
        sub = 1'b0;
        forever #4 sub = ~sub;
    end

    //////////////////////////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////////////////////////

    // {err, rdata} for an access against the shadow state
    function automatic logic [32:0] predict(input logic [31:0] addr, input logic [1:0] size,
                                            input logic sgn);
        logic        err;
        logic [31:0] base;
        logic [31:0] w;
        logic [31:0] b;
        base = {addr[31:2], 2'b00};
        err  = (size == 2'd3) || (size == SIZE_HALF && addr[0])
               || (size == SIZE_WORD && addr[1:0] != 2'b00);
        if (addr < MEM_SIZE) begin
            w = {shadow_mem[MA'(base + 32'd3)], shadow_mem[MA'(base + 32'd2)],
                 shadow_mem[MA'(base + 32'd1)], shadow_mem[MA'(base)]};
        end else if (addr[31:3] == GPIO_BASE[31:3]) begin
            w = addr[2] ? shadow_in : shadow_out;
            // pins above GPIO_W read zero
            w = w & ((32'd1 << GPIO_W) - 32'd1);
        end else begin
            err = 1'b1;
            w   = '0;
        end
        b = w >> (8 * addr[1:0]);
        case (size)
            SIZE_BYTE: b = sgn ? {{24{b[7]}}, b[7:0]} : {24'd0, b[7:0]};
            SIZE_HALF: b = sgn ? {{16{b[15]}}, b[15:0]} : {16'd0, b[15:0]};
            default:   b = w;
        endcase
        return {err, b};
    endfunction

    // merge an accepted store into the shadow
    function automatic void apply_store(input logic [31:0] addr, input logic [1:0] size,
                                        input logic [31:0] wdata);
        logic [31:0] a;
        logic [31:0] d;
        a = addr;
        d = wdata;
        // low byte first
        for (int i = 0; i < (1 << size); i++) begin
            if (addr < MEM_SIZE) begin
                shadow_mem[MA'(a)] = d[7:0];
            end else if (!addr[2]) begin
                shadow_out = (shadow_out & ~(32'hFF << (8 * a[1:0])))
                             | ({24'd0, d[7:0]} << (8 * a[1:0]));
            end
            a = a + 32'd1;
            d = d >> 8;
        end
    endfunction

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected) begin
            $display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
            mismatches++;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // driver
    //////////////////////////////////////////////////////////////////////

    // one request, held until accepted, expectation queued at the transfer
    task automatic access(input string name, input logic wr, input logic [31:0] addr,
                          input logic [1:0] size, input logic sgn, input logic [31:0] wdata);
        logic [32:0] exp;
        @(negedge sub);
        req_valid  = 1'b1;
        req_write  = wr;
        req_addr   = addr;
        req_size   = size;
        req_signed = sgn;
        req_wdata  = wdata;
        while (req_ready !== 1'b1) begin
            @(negedge sub);
        end
        exp = predict(addr, size, sgn);
        exp_name.push_back(name);
        exp_data.push_back(exp[31:0]);
        exp_err.push_back(exp[32]);
        exp_read.push_back(!wr);
        if (wr && !exp[32]) begin
            apply_store(addr, size, wdata);
        end
        @(negedge sub);
        req_valid = 1'b0;
        // response due in the cycle right after the transfer
        check({name, " rsp_valid"}, 32'd1, 32'(rsp_valid));
    endtask

    // responses are stable at the falling edge
    initial begin : compare_responses
        string       name;
        logic [31:0] data;
        logic        err;
        logic        rd;
        forever begin
            @(negedge sub);
            if (rsp_valid === 1'b1) begin
                if (exp_name.size() == 0) begin
                    $display("ERROR: response arrived with no request outstanding at %0t", $time);
                    failures++;
                end else begin
                    name = exp_name.pop_front();
                    data = exp_data.pop_front();
                    err  = exp_err.pop_front();
                    rd   = exp_read.pop_front();
                    check({name, " err"}, 32'(err), 32'(rsp_err));
                    if (rd && !err) begin
                        check(name, data, rsp_rdata);
                    end
                end
            end
        end
    end

    initial begin : watchdog
        repeat (LIMIT) @(posedge sub);
        $display("ERROR: watchdog expired after %0d cycles, DUT stopped responding", LIMIT);
        $display("SIMULATION FAILED");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin : stimulus
        logic [31:0] r_addr;
        logic [31:0] r_ctl;
        logic [31:0] r_data;
        logic [1:0]  sz;
        int          clear_cycles;
        seed       = 1930;
        mismatches = 0;
        failures   = 0;
        rst        = 1'b1;
        req_valid  = 1'b0;
        req_write  = 1'b0;
        req_addr   = '0;
        req_size   = SIZE_WORD;
        req_signed = 1'b0;
        req_wdata  = '0;
        gpio_in    = '0;
        shadow_mem = '{default: 8'h00};
        shadow_out = '0;
        shadow_in  = '0;
        repeat (16) @(negedge sub);
        rst = 1'b0;

        // ready low for one cycle per word
        clear_cycles = 0;
        while (req_ready !== 1'b1) begin
            clear_cycles++;
            @(negedge sub);
        end
        check("clear length", WORDS, 32'(clear_cycles));
        for (int i = 0; i < int'(WORDS); i++) begin
            access("zero sweep", 1'b0, 32'(i * 4), SIZE_WORD, 1'b0, '0);
        end

        // word write and read back
        access("word write", 1'b1, 32'h00, SIZE_WORD, 1'b0, 32'hDEAD_BEEF);
        access("word write", 1'b1, 32'h04, SIZE_WORD, 1'b0, 32'h0123_4567);
        access("word read", 1'b0, 32'h00, SIZE_WORD, 1'b0, '0);
        access("word read", 1'b0, 32'h04, SIZE_WORD, 1'b0, '0);
        for (int i = 0; i < N_RAND; i++) begin
            r_addr = $random(seed);
            r_ctl  = $random(seed);
            r_data = $random(seed);
            sz     = (r_ctl[3:2] == 2'd3) ? SIZE_WORD : r_ctl[3:2];
            // aligned to the size
            r_addr = r_addr & (MEM_SIZE - 32'd1) & ~((32'd1 << sz) - 32'd1);
            access("random mix", r_ctl[0], r_addr, sz, r_ctl[1], r_data);
        end

        // sub-word merge and extension
        access("merge base", 1'b1, 32'h40, SIZE_WORD, 1'b0, 32'h0000_0000);
        access("byte store", 1'b1, 32'h41, SIZE_BYTE, 1'b0, 32'h0000_0085);
        access("half store", 1'b1, 32'h42, SIZE_HALF, 1'b0, 32'h0000_F00D);
        access("merged word", 1'b0, 32'h40, SIZE_WORD, 1'b0, '0);
        access("byte unsigned", 1'b0, 32'h41, SIZE_BYTE, 1'b0, '0);
        access("byte signed", 1'b0, 32'h41, SIZE_BYTE, 1'b1, '0);
        access("half unsigned", 1'b0, 32'h42, SIZE_HALF, 1'b0, '0);
        access("half signed", 1'b0, 32'h42, SIZE_HALF, 1'b1, '0);
        access("half signed low", 1'b0, 32'h40, SIZE_HALF, 1'b1, '0);

        // misaligned, memory must stay untouched
        access("misaligned base", 1'b1, 32'h50, SIZE_WORD, 1'b0, 32'hCAFE_F00D);
        access("misaligned word", 1'b1, 32'h52, SIZE_WORD, 1'b0, 32'h1234_5678);
        access("misaligned half", 1'b1, 32'h53, SIZE_HALF, 1'b0, 32'h0000_ABCD);
        access("misaligned read", 1'b0, 32'h51, SIZE_WORD, 1'b0, '0);
        access("after misaligned", 1'b0, 32'h50, SIZE_WORD, 1'b0, '0);

        // unmapped
        access("unmapped read", 1'b0, MEM_SIZE, SIZE_WORD, 1'b0, '0);
        access("unmapped write", 1'b1, MEM_SIZE, SIZE_WORD, 1'b0, 32'h5555_AAAA);
        access("gpio gap read", 1'b0, GPIO_BASE + 32'd8, SIZE_WORD, 1'b0, '0);
        access("gpio gap write", 1'b1, GPIO_BASE + 32'd8, SIZE_WORD, 1'b0, 32'h1);
        access("high write", 1'b1, 32'h8000_0000, SIZE_BYTE, 1'b0, 32'h77);
        access("high read", 1'b0, 32'h8000_0000, SIZE_BYTE, 1'b0, '0);
        // word 0 is where the unmapped writes would alias
        access("after unmapped", 1'b0, 32'h00, SIZE_WORD, 1'b0, '0);

        // gpio output register
        access("gpio out write", 1'b1, GPIO_BASE, SIZE_WORD, 1'b0, 32'h0000_A5C3);
        check("gpio_out", 32'(shadow_out[GPIO_W-1:0]), 32'(gpio_out));
        access("gpio out read", 1'b0, GPIO_BASE, SIZE_WORD, 1'b0, '0);
        access("gpio byte write", 1'b1, GPIO_BASE + 32'd1, SIZE_BYTE, 1'b0, 32'h7E);
        check("gpio_out byte", 32'(shadow_out[GPIO_W-1:0]), 32'(gpio_out));
        access("gpio half read", 1'b0, GPIO_BASE, SIZE_HALF, 1'b1, '0);
        // inputs after the synchronizer
        @(negedge sub);
        gpio_in   = 16'h9F31;
        shadow_in = 32'h0000_9F31;
        repeat (2) @(negedge sub);
        access("gpio in read", 1'b0, GPIO_BASE + 32'd4, SIZE_WORD, 1'b0, '0);
        access("gpio in byte", 1'b0, GPIO_BASE + 32'd5, SIZE_BYTE, 1'b1, '0);
        // offset 4 is read only
        access("gpio in write", 1'b1, GPIO_BASE + 32'd4, SIZE_WORD, 1'b0, 32'hFFFF_FFFF);
        check("gpio_out kept", 32'(shadow_out[GPIO_W-1:0]), 32'(gpio_out));
        access("gpio in reread", 1'b0, GPIO_BASE + 32'd4, SIZE_WORD, 1'b0, '0);
        access("gpio out reread", 1'b0, GPIO_BASE, SIZE_WORD, 1'b0, '0);

        repeat (4) @(negedge sub);
        if (exp_name.size() != 0) begin
            $display("ERROR: %0d responses never arrived", exp_name.size());
            failures++;
        end
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: hw/tcm_subsystem.sv
// tightly coupled memory subsystem
`timescale 1ns/1ns

module tcm_subsystem #(
    parameter int unsigned                MEM_SIZE  = 4096,
    parameter logic [tcm_pkg::ADDR_W-1:0] GPIO_BASE = 32'h0001_0000,
    parameter int unsigned                GPIO_W    = 16
) (
    input  logic                       sub,
    input  logic                       rst,
    // request channel
    input  logic                       req_valid,
    output logic                       req_ready,
    input  logic                       req_write,
    input  logic [tcm_pkg::ADDR_W-1:0] req_addr,
    input  logic [1:0]                 req_size,
    input  logic                       req_signed,
    input  tcm_pkg::data_word_t        req_wdata,
    // response
    output logic                       rsp_valid,
    output tcm_pkg::data_word_t        rsp_rdata,
    output logic                       rsp_err,
    // pins
    input  logic [GPIO_W-1:0]          gpio_in,
    output logic [GPIO_W-1:0]          gpio_out
);

    import tcm_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // internal wires
    //////////////////////////////////////////////////////////////////////

    // alignment to decoder
    logic              dn_valid;
    logic              dn_ready;
    logic              dn_write;
    logic [ADDR_W-1:0] dn_addr;
    logic              dn_misaligned;
    logic [3:0]        dn_byte_en;
    data_word_t        dn_wdata;
    logic              dn_rsp_valid;
    data_word_t        dn_rsp_rdata;
    logic              dn_rsp_err;
    // decoder to subordinates
    logic              mem_valid;
    logic              mem_ready;
    data_word_t        mem_rdata;
    logic              gpio_valid;
    data_word_t        gpio_rdata;
    logic              sel_write;
    logic [ADDR_W-1:0] sel_addr;
    logic [3:0]        sel_byte_en;
    data_word_t        sel_wdata;

    //////////////////////////////////////////////////////////////////////
    // instances
    //////////////////////////////////////////////////////////////////////

    lsu_align align_i (
        .sub           (sub),
        .rst           (rst),
        .req_valid     (req_valid),
        .req_ready     (req_ready),
        .req_write     (req_write),
        .req_addr      (req_addr),
        .req_size      (req_size),
        .req_signed    (req_signed),
        .req_wdata     (req_wdata),
        .rsp_valid     (rsp_valid),
        .rsp_rdata     (rsp_rdata),
        .rsp_err       (rsp_err),
        .dn_valid      (dn_valid),
        .dn_ready      (dn_ready),
        .dn_write      (dn_write),
        .dn_addr       (dn_addr),
        .dn_misaligned (dn_misaligned),
        .dn_byte_en    (dn_byte_en),
        .dn_wdata      (dn_wdata),
        .dn_rsp_valid  (dn_rsp_valid),
        .dn_rsp_rdata  (dn_rsp_rdata),
        .dn_rsp_err    (dn_rsp_err)
    );

    bus_decoder #(
        .MEM_SIZE  (MEM_SIZE),
        .GPIO_BASE (GPIO_BASE)
    ) decoder_i (
        .sub            (sub),
        .rst            (rst),
        .up_valid       (dn_valid),
        .up_ready       (dn_ready),
        .up_write       (dn_write),
        .up_addr        (dn_addr),
        .up_misaligned  (dn_misaligned),
        .up_byte_en     (dn_byte_en),
        .up_wdata       (dn_wdata),
        .up_rsp_valid   (dn_rsp_valid),
        .up_rsp_rdata   (dn_rsp_rdata),
        .up_rsp_err     (dn_rsp_err),
        .mem_valid      (mem_valid),
        .mem_ready      (mem_ready),
        .mem_rsp_rdata  (mem_rdata),
        .gpio_valid     (gpio_valid),
        .gpio_rsp_rdata (gpio_rdata),
        .sel_write      (sel_write),
        .sel_addr       (sel_addr),
        .sel_byte_en    (sel_byte_en),
        .sel_wdata      (sel_wdata)
    );

    soc_memory #(
        .MEM_SIZE (MEM_SIZE)
    ) memory_i (
        .sub     (sub),
        .rst     (rst),
        .valid   (mem_valid),
        .ready   (mem_ready),
        .write   (sel_write),
        .addr    (sel_addr),
        .byte_en (sel_byte_en),
        .wdata   (sel_wdata),
        .rdata   (mem_rdata)
    );

    soc_gpio #(
        .GPIO_W (GPIO_W)
    ) gpio_i (
        .sub      (sub),
        .rst      (rst),
        .valid    (gpio_valid),
        .write    (sel_write),
        .addr     (sel_addr),
        .byte_en  (sel_byte_en),
        .wdata    (sel_wdata),
        .rdata    (gpio_rdata),
        .gpio_in  (gpio_in),
        .gpio_out (gpio_out)
    );

endmodule

// File: hw/soc_gpio.sv
// gpio register block
`timescale 1ns/1ns

module soc_gpio #(
    parameter int unsigned GPIO_W = 16
) (
    input  logic                       sub,
    input  logic                       rst,
    input  logic                       valid,
    input  logic                       write,
    input  logic [tcm_pkg::ADDR_W-1:0] addr,
    input  logic [3:0]                 byte_en,
    input  tcm_pkg::data_word_t        wdata,
    output tcm_pkg::data_word_t        rdata,
    input  logic [GPIO_W-1:0]          gpio_in,
    output logic [GPIO_W-1:0]          gpio_out
);

    import tcm_pkg::*;

    data_word_t        out_q;
    // two-flop input synchronizer
    logic [GPIO_W-1:0] sync_1;
    logic [GPIO_W-1:0] sync_2;

    // output register, offset 0
    always_ff @(posedge sub) begin
        if (rst) begin
            out_q <= '0;
        end else if (valid && write && !addr[2]) begin
            for (int i = 0; i < 4; i++) begin
                if (byte_en[i]) begin
                    out_q.lane[i] <= wdata.lane[i];
                end
            end
        end
    end

    assign gpio_out = out_q.word[GPIO_W-1:0];

    always_ff @(posedge sub) begin
        sync_1 <= gpio_in;
        sync_2 <= sync_1;
    end

    // registered read, zero above GPIO_W
    always_ff @(posedge sub) begin
        if (valid && !write) begin
            rdata.word <= addr[2] ? 32'(sync_2) : 32'(out_q.word[GPIO_W-1:0]);
        end
    end

endmodule

// File: hw/soc_memory.sv
// single-port word memory
`timescale 1ns/1ns

module soc_memory #(
    parameter int unsigned MEM_SIZE = 4096
) (
    input  logic                       sub,
    input  logic                       rst,
    input  logic                       valid,
    output logic                       ready,
    input  logic                       write,
    input  logic [tcm_pkg::ADDR_W-1:0] addr,
    input  logic [3:0]                 byte_en,
    input  tcm_pkg::data_word_t        wdata,
    output tcm_pkg::data_word_t        rdata
);

    import tcm_pkg::*;

    // word count and word index width
    localparam int unsigned WORDS = MEM_SIZE / 4;
    localparam int unsigned AW    = $clog2(WORDS);

    data_word_t    mem [WORDS];
    logic [AW-1:0] idx;
    logic          trn;
    // clear sequencer
    logic          clr_busy;
    logic [AW-1:0] clr_idx;

    assign idx   = addr[AW+1:2];
    assign ready = !clr_busy;
    assign trn   = valid && ready;

    //////////////////////////////////////////////////////////////////////
    // post-reset clear
    //////////////////////////////////////////////////////////////////////

    // one word per cycle, ready held low meanwhile
    always_ff @(posedge sub) begin
        if (rst) begin
            clr_busy <= 1'b1;
            clr_idx  <= '0;
        end else if (clr_busy) begin
            clr_idx <= clr_idx + 1'b1;
            if (clr_idx == AW'(WORDS - 1)) begin
                clr_busy <= 1'b0;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // array access
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge sub) begin
        if (clr_busy) begin
            mem[clr_idx] <= '0;
        end else if (trn) begin
            if (write) begin
                // per-lane write
                for (int i = 0; i < 4; i++) begin
                    if (byte_en[i]) begin
                        mem[idx].lane[i] <= wdata.lane[i];
                    end
                end
            end else begin
                rdata <= mem[idx];
            end
        end
    end

    // stalled request is held
    a_hold: assert property (@(posedge sub) disable iff (rst)
        (valid && !ready) |=> valid && $stable(write) && $stable(addr)
            && $stable(byte_en) && $stable(wdata));

endmodule

// File: hw/bus_decoder.sv
// address decoder and response steering
`timescale 1ns/1ns

module bus_decoder #(
    parameter int unsigned                    MEM_SIZE  = 4096,
    parameter logic [tcm_pkg::ADDR_W-1:0]     GPIO_BASE = 32'h0001_0000
) (
    input  logic                       sub,
    input  logic                       rst,
    // upstream from alignment
    input  logic                       up_valid,
    output logic                       up_ready,
    input  logic                       up_write,
    input  logic [tcm_pkg::ADDR_W-1:0] up_addr,
    input  logic                       up_misaligned,
    input  logic [3:0]                 up_byte_en,
    input  tcm_pkg::data_word_t        up_wdata,
    output logic                       up_rsp_valid,
    output tcm_pkg::data_word_t        up_rsp_rdata,
    output logic                       up_rsp_err,
    // memory
    output logic                       mem_valid,
    input  logic                       mem_ready,
    input  tcm_pkg::data_word_t        mem_rsp_rdata,
    // gpio
    output logic                       gpio_valid,
    input  tcm_pkg::data_word_t        gpio_rsp_rdata,
    // shared request fields
    output logic                       sel_write,
    output logic [tcm_pkg::ADDR_W-1:0] sel_addr,
    output logic [3:0]                 sel_byte_en,
    output tcm_pkg::data_word_t        sel_wdata
);

    import tcm_pkg::*;

    logic hit_mem;
    logic hit_gpio;
    logic bad;
    logic trn;
    // response state
    logic rsp_q;
    logic err_q;
    logic gpio_q;

    //////////////////////////////////////////////////////////////////////
    // decode
    //////////////////////////////////////////////////////////////////////

    assign hit_mem  = up_addr < ADDR_W'(MEM_SIZE);
    // two-word window
    assign hit_gpio = up_addr[ADDR_W-1:3] == GPIO_BASE[ADDR_W-1:3];
    assign bad      = up_misaligned || !(hit_mem || hit_gpio);

    // only the memory stalls, errors also wait for it
    assign up_ready = mem_ready;
    assign trn      = up_valid && up_ready;

    assign mem_valid  = up_valid && hit_mem && !up_misaligned;
    // gpio has no ready, so gate with the shared one
    assign gpio_valid = trn && hit_gpio && !up_misaligned;

    assign sel_write   = up_write;
    assign sel_addr    = up_addr;
    assign sel_byte_en = up_byte_en;
    assign sel_wdata   = up_wdata;

    //////////////////////////////////////////////////////////////////////
    // response
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge sub) begin
        if (rst) begin
            rsp_q  <= 1'b0;
            err_q  <= 1'b0;
            gpio_q <= 1'b0;
        end else begin
            rsp_q <= trn;
            err_q <= trn && bad;
            if (trn) begin
                gpio_q <= hit_gpio;
            end
        end
    end

    assign up_rsp_valid = rsp_q;
    assign up_rsp_err   = err_q;
    assign up_rsp_rdata = gpio_q ? gpio_rsp_rdata : mem_rsp_rdata;

    // one target at most
    a_one_target: assert property (@(posedge sub) disable iff (rst)
        !(mem_valid && gpio_valid));

endmodule

// File: hw/lsu_align.sv
// load/store alignment
`timescale 1ns/1ns

module lsu_align (
    input  logic                       sub,
    input  logic                       rst,
    // requester channel
    input  logic                       req_valid,
    output logic                       req_ready,
    input  logic                       req_write,
    input  logic [tcm_pkg::ADDR_W-1:0] req_addr,
    input  logic [1:0]                 req_size,
    input  logic                       req_signed,
    input  tcm_pkg::data_word_t        req_wdata,
    output logic                       rsp_valid,
    output tcm_pkg::data_word_t        rsp_rdata,
    output logic                       rsp_err,
    // downstream to the decoder
    output logic                       dn_valid,
    input  logic                       dn_ready,
    output logic                       dn_write,
    output logic [tcm_pkg::ADDR_W-1:0] dn_addr,
    output logic                       dn_misaligned,
    output logic [3:0]                 dn_byte_en,
    output tcm_pkg::data_word_t        dn_wdata,
    input  logic                       dn_rsp_valid,
    input  tcm_pkg::data_word_t        dn_rsp_rdata,
    input  logic                       dn_rsp_err
);

    import tcm_pkg::*;

    logic       trn;
    logic [1:0] off;
    // access attributes kept for the response cycle
    logic [1:0] size_q;
    logic [1:0] off_q;
    logic       sign_q;
    // addressed lanes of the returned word
    logic [7:0]  ld_byte;
    logic [15:0] ld_half;

    assign trn = req_valid && req_ready;
    assign off = req_addr[1:0];

    //////////////////////////////////////////////////////////////////////
    // request path, combinational
    //////////////////////////////////////////////////////////////////////

    // handshake passes straight through
    assign dn_valid  = req_valid;
    assign req_ready = dn_ready;
    assign dn_write  = req_write;
    // word address only, lanes carry the offset
    assign dn_addr   = {req_addr[ADDR_W-1:2], 2'b00};

    // alignment check and byte enables
    always_comb begin
        case (req_size)
            SIZE_BYTE: begin
                dn_misaligned = 1'b0;
                dn_byte_en    = 4'b0001 << off;
            end
            SIZE_HALF: begin
                dn_misaligned = off[0];
                dn_byte_en    = 4'b0011 << off;
            end
            SIZE_WORD: begin
                dn_misaligned = |off;
                dn_byte_en    = 4'b1111;
            end
            default: begin
                // reserved size, reject
                dn_misaligned = 1'b1;
                dn_byte_en    = 4'b0000;
            end
        endcase
    end

    // move low lanes up to the addressed offset
    always_comb begin
        dn_wdata = '0;
        for (int i = 0; i < 4; i++) begin
            if (i >= int'(off)) begin
                dn_wdata.lane[i] = req_wdata.lane[i - int'(off)];
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // response path
    //////////////////////////////////////////////////////////////////////

    // capture at the transfer
    always_ff @(posedge sub) begin
        if (trn) begin
            size_q <= req_size;
            off_q  <= off;
            sign_q <= req_signed;
        end
    end

    assign ld_byte = dn_rsp_rdata.lane[off_q];
    // half offset is 0 or 2 on error-free loads
    assign ld_half = {dn_rsp_rdata.lane[off_q | 2'd1], dn_rsp_rdata.lane[off_q & 2'd2]};

    // zero or sign extension
    always_comb begin
        case (size_q)
            SIZE_BYTE: rsp_rdata.word = {{24{sign_q & ld_byte[7]}}, ld_byte};
            SIZE_HALF: rsp_rdata.word = {{16{sign_q & ld_half[15]}}, ld_half};
            default:   rsp_rdata.word = dn_rsp_rdata.word;
        endcase
    end

    assign rsp_valid = dn_rsp_valid;
    assign rsp_err   = dn_rsp_err;

    // reserved size code never reaches a transfer
    a_size_legal: assert property (@(posedge sub) disable iff (rst)
        trn |-> req_size != 2'd3);

    // every transfer gets its response on the next edge
    a_rsp_timing: assert property (@(posedge sub) disable iff (rst)
        trn |=> rsp_valid);

endmodule

// File: hw/tcm_pkg.sv
// tcm subsystem shared types
package tcm_pkg;

    //////////////////////////////////////////////////////////////////////
    // bus widths
    //////////////////////////////////////////////////////////////////////

    // byte address width of the requester port
    localparam int ADDR_W = 32;

    //////////////////////////////////////////////////////////////////////
    // access size codes
    //////////////////////////////////////////////////////////////////////

    // encoding of req_size
    localparam logic [1:0] SIZE_BYTE = 2'd0;
    localparam logic [1:0] SIZE_HALF = 2'd1;
    localparam logic [1:0] SIZE_WORD = 2'd2;
    // 2'd3 is reserved, treated as misaligned

    //////////////////////////////////////////////////////////////////////
    // data word
    //////////////////////////////////////////////////////////////////////

    // one 32-bit data word seen two ways
    // whole word for reads and transport
    // byte lanes for shifting and byte-enabled writes
    typedef union packed {
        logic [31:0]     word;
        logic [3:0][7:0] lane;
    } data_word_t;

endpackage
